// ==== hw/ant_cfg.svh ====
`ifndef ANT_CFG_SVH
`define ANT_CFG_SVH

// Ant coordinate widths, sized to the frame buffer
`define ANT_X_WIDTH 8
`define ANT_Y_WIDTH 7

`define ANT_COLOUR_WIDTH 3

// Index of an ant in the datapath memory
`define ANT_ID_WIDTH 4

// Datapath result and opcode fields
`define ANT_RESULT_WIDTH 8
`define ANT_OPCODE_WIDTH 2

// Sprite size in pixels
`define ANT_BLOCK_WIDTH 4
`define ANT_BLOCK_HEIGHT 4

// Red sprite
`define ANT_COLOUR `ANT_COLOUR_WIDTH'b100

// One datapath instruction word
`define ANT_INSTR_WIDTH 24

`endif

// ==== hw/ant_pkg.sv ====
`default_nettype none

`include "ant_cfg.svh"

package ant_pkg;

    typedef enum logic [`ANT_OPCODE_WIDTH-1:0] {
        op_mem_read  = `ANT_OPCODE_WIDTH'd0,
        op_mem_write = `ANT_OPCODE_WIDTH'd1,
        op_draw      = `ANT_OPCODE_WIDTH'd2
    } opcode_e;

    // Which stored coordinate of an ant is addressed
    typedef enum logic {
        field_x = 1'b0,
        field_y = 1'b1
    } ant_field_e;

    typedef struct packed {
        ant_field_e                field;
        logic [`ANT_ID_WIDTH-1:0]  id;
    } ant_addr_t;

    localparam int MEM_PAD_WIDTH = `ANT_INSTR_WIDTH - `ANT_RESULT_WIDTH
                                 - $bits(ant_addr_t) - `ANT_OPCODE_WIDTH;
    localparam int DRAW_PAD_WIDTH = `ANT_INSTR_WIDTH - 1 - `ANT_COLOUR_WIDTH
                                  - `ANT_Y_WIDTH - `ANT_X_WIDTH - `ANT_OPCODE_WIDTH;

    // Memory read or write, opcode in the low bits
    typedef struct packed {
        logic [MEM_PAD_WIDTH-1:0]     pad;
        logic [`ANT_RESULT_WIDTH-1:0] wdata;
        ant_addr_t                    addr;
        opcode_e                      opcode;
    } mem_instr_t;

    // Single pixel plot into the frame buffer
    typedef struct packed {
        logic [DRAW_PAD_WIDTH-1:0]    pad;
        logic                         plot;
        logic [`ANT_COLOUR_WIDTH-1:0] colour;
        logic [`ANT_Y_WIDTH-1:0]      y;
        logic [`ANT_X_WIDTH-1:0]      x;
        opcode_e                      opcode;
    } draw_instr_t;

    // The datapath decodes the same word by its opcode
    typedef union packed {
        mem_instr_t  mem;
        draw_instr_t draw;
    } instr_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

    typedef enum logic {
        cmd_draw   = 1'b0,
        cmd_update = 1'b1
    } ant_cmd_e;

endpackage

`default_nettype wire

// ==== hw/dp_request.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module dp_request (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         req,
    input  ant_pkg::instr_t              instr,
    output logic                         done,
    output logic [`ANT_RESULT_WIDTH-1:0] result,
    output logic                         start_dp,
    output ant_pkg::instr_t              instruction_dp,
    input  logic                         finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0] result_dp
);

    typedef enum logic [1:0] {
        st_idle,
        st_strobe,
        st_wait
    } state_e;

    state_e state;
    // High in the second strobe cycle
    logic   strobe_cnt;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state          <= st_idle;
            strobe_cnt     <= 1'b0;
            start_dp       <= 1'b0;
            instruction_dp <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req) begin
                        instruction_dp <= instr;
                        start_dp       <= 1'b1;
                        strobe_cnt     <= 1'b0;
                        state          <= st_strobe;
                    end
                end
                st_strobe: begin
                    strobe_cnt <= 1'b1;
                    if (strobe_cnt) begin
                        start_dp <= 1'b0;
                        state    <= st_wait;
                    end
                end
                st_wait: begin
                    if (finished_dp) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Completion is passed through in the same cycle as finished_dp
    assign done   = (state == st_wait) && finished_dp;
    assign result = result_dp;

endmodule

`default_nettype wire

// ==== hw/ant_draw.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module ant_draw (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    output logic                         done_cmd,
    input  logic [`ANT_ID_WIDTH-1:0]     id,
    output logic                         req,
    output ant_pkg::instr_t              instr,
    input  logic                         done,
    input  logic [`ANT_RESULT_WIDTH-1:0] result
);

    import ant_pkg::*;

    localparam int DX_WIDTH = $clog2(`ANT_BLOCK_WIDTH);
    localparam int DY_WIDTH = $clog2(`ANT_BLOCK_HEIGHT);

    typedef enum logic [2:0] {
        st_idle,
        st_read_x,
        st_wait_x,
        st_read_y,
        st_wait_y,
        st_draw,
        st_wait_draw
    } state_e;

    state_e                   state;
    logic [`ANT_ID_WIDTH-1:0] id_q;
    // Top left pixel of the sprite
    logic [`ANT_X_WIDTH-1:0]  corner_x;
    logic [`ANT_Y_WIDTH-1:0]  corner_y;
    logic [DX_WIDTH-1:0]      dx;
    logic [DY_WIDTH-1:0]      dy;
    logic                     last_col;
    logic                     last_pixel;

    assign last_col   = (dx == DX_WIDTH'(`ANT_BLOCK_WIDTH - 1));
    assign last_pixel = last_col && (dy == DY_WIDTH'(`ANT_BLOCK_HEIGHT - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
            dx    <= '0;
            dy    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        dx    <= '0;
                        dy    <= '0;
                        state <= st_read_x;
                    end
                end
                st_read_x: state <= st_wait_x;
                st_wait_x: if (done) state <= st_read_y;
                st_read_y: state <= st_wait_y;
                st_wait_y: if (done) state <= st_draw;
                st_draw:   state <= st_wait_draw;
                st_wait_draw: begin
                    if (done) begin
                        // Row order, x offset steps fastest
                        if (last_pixel) begin
                            state <= st_idle;
                        end else begin
                            state <= st_draw;
                            if (last_col) begin
                                dx <= '0;
                                dy <= dy + 1'b1;
                            end else begin
                                dx <= dx + 1'b1;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_idle && start) id_q <= id;
        if (state == st_wait_x && done) corner_x <= result[`ANT_X_WIDTH-1:0] - `ANT_X_WIDTH'd1;
        if (state == st_wait_y && done) corner_y <= result[`ANT_Y_WIDTH-1:0] - `ANT_Y_WIDTH'd1;
    end

    always_comb begin
        req   = (state == st_read_x) || (state == st_read_y) || (state == st_draw);
        instr = '0;
        case (state)
            st_read_x, st_read_y: begin
                instr.mem.opcode     = op_mem_read;
                instr.mem.addr.id    = id_q;
                instr.mem.addr.field = (state == st_read_x) ? field_x : field_y;
            end
            st_draw: begin
                instr.draw.opcode = op_draw;
                instr.draw.plot   = 1'b1;
                instr.draw.colour = `ANT_COLOUR;
                instr.draw.x      = corner_x + `ANT_X_WIDTH'(dx);
                instr.draw.y      = corner_y + `ANT_Y_WIDTH'(dy);
            end
            default: instr = '0;
        endcase
    end

    assign done_cmd = (state == st_wait_draw) && done && last_pixel;

endmodule

`default_nettype wire

// ==== hw/ant_update.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module ant_update (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    output logic                         done_cmd,
    input  logic [`ANT_ID_WIDTH-1:0]     id,
    input  ant_pkg::move_t               move,
    output logic                         req,
    output ant_pkg::instr_t              instr,
    input  logic                         done,
    input  logic [`ANT_RESULT_WIDTH-1:0] result
);

    import ant_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_read_x,
        st_wait_x,
        st_read_y,
        st_wait_y,
        st_write_x,
        st_wait_write_x,
        st_write_y,
        st_wait_write_y
    } state_e;

    state_e                   state;
    logic [`ANT_ID_WIDTH-1:0] id_q;
    move_t                    move_q;
    logic [`ANT_X_WIDTH-1:0]  x_q;
    logic [`ANT_Y_WIDTH-1:0]  y_q;
    logic                     is_read;
    logic                     is_write;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:         if (start) state <= st_read_x;
                st_read_x:       state <= st_wait_x;
                st_wait_x:       if (done) state <= st_read_y;
                st_read_y:       state <= st_wait_y;
                st_wait_y:       if (done) state <= st_write_x;
                st_write_x:      state <= st_wait_write_x;
                st_wait_write_x: if (done) state <= st_write_y;
                st_write_y:      state <= st_wait_write_y;
                st_wait_write_y: if (done) state <= st_idle;
                default:         state <= st_idle;
            endcase
        end
    end

    // The move is applied as y arrives, so both coordinates are ready to store
    always_ff @(posedge clock) begin
        if (state == st_idle && start) begin
            id_q   <= id;
            move_q <= move;
        end
        if (state == st_wait_x && done) begin
            x_q <= result[`ANT_X_WIDTH-1:0];
        end
        if (state == st_wait_y && done) begin
            // Opposite bits cancel, wrapping at the coordinate width
            x_q <= x_q + `ANT_X_WIDTH'(move_q.right) - `ANT_X_WIDTH'(move_q.left);
            y_q <= result[`ANT_Y_WIDTH-1:0] + `ANT_Y_WIDTH'(move_q.down)
                   - `ANT_Y_WIDTH'(move_q.up);
        end
    end

    assign is_read  = (state == st_read_x) || (state == st_read_y);
    assign is_write = (state == st_write_x) || (state == st_write_y);

    always_comb begin
        req   = is_read || is_write;
        instr = '0;
        if (is_read || is_write) begin
            instr.mem.opcode  = is_write ? op_mem_write : op_mem_read;
            instr.mem.addr.id = id_q;
            if (state == st_read_x || state == st_write_x) begin
                instr.mem.addr.field = field_x;
            end else begin
                instr.mem.addr.field = field_y;
            end
            if (state == st_write_x) begin
                instr.mem.wdata = `ANT_RESULT_WIDTH'(x_q);
            end else if (state == st_write_y) begin
                instr.mem.wdata = `ANT_RESULT_WIDTH'(y_q);
            end
        end
    end

    assign done_cmd = (state == st_wait_write_y) && done;

endmodule

`default_nettype wire

// ==== hw/dp_select.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module dp_select (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    input  ant_pkg::ant_cmd_e            cmd,
    output logic                         finished,
    output logic                         draw_start,
    output logic                         update_start,
    input  logic                         draw_done,
    input  logic                         update_done,
    input  logic                         draw_req,
    input  logic                         update_req,
    input  ant_pkg::instr_t              draw_instr,
    input  ant_pkg::instr_t              update_instr,
    output logic                         req,
    output ant_pkg::instr_t              instr,
    input  logic                         done,
    input  logic [`ANT_RESULT_WIDTH-1:0] result,
    output logic                         draw_dp_done,
    output logic                         update_dp_done,
    output logic [`ANT_RESULT_WIDTH-1:0] draw_dp_result,
    output logic [`ANT_RESULT_WIDTH-1:0] update_dp_result
);

    import ant_pkg::*;

    ant_cmd_e cmd_q;
    logic     accept;
    logic     draw_active;
    logic     cmd_done;

    // A start while busy is dropped
    assign accept       = start && finished;
    assign draw_start   = accept && (cmd == cmd_draw);
    assign update_start = accept && (cmd == cmd_update);

    assign draw_active = (cmd_q == cmd_draw);
    assign cmd_done    = draw_active ? draw_done : update_done;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            finished <= 1'b1;
            cmd_q    <= cmd_draw;
        end else if (accept) begin
            finished <= 1'b0;
            cmd_q    <= cmd;
        end else if (cmd_done) begin
            finished <= 1'b1;
        end
    end

    // Only the sequencer of the latched command talks to the datapath
    assign req              = draw_active ? draw_req : update_req;
    assign instr            = draw_active ? draw_instr : update_instr;
    assign draw_dp_done     = done && draw_active;
    assign update_dp_done   = done && !draw_active;
    assign draw_dp_result   = draw_active ? result : '0;
    assign update_dp_result = draw_active ? '0 : result;

endmodule

`default_nettype wire

// ==== hw/ant_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module ant_unit (
    input  logic                         clock,
    input  logic                         resetn,
    input  logic                         start,
    input  ant_pkg::ant_cmd_e            cmd,
    input  logic [`ANT_ID_WIDTH-1:0]     id,
    input  ant_pkg::move_t               move,
    output logic                         finished,
    output logic                         start_dp,
    output ant_pkg::instr_t              instruction_dp,
    input  logic                         finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0] result_dp
);

    import ant_pkg::*;

    logic                         draw_start;
    logic                         update_start;
    logic                         draw_done;
    logic                         update_done;
    logic                         draw_req;
    logic                         update_req;
    instr_t                       draw_instr;
    instr_t                       update_instr;
    logic                         draw_dp_done;
    logic                         update_dp_done;
    logic [`ANT_RESULT_WIDTH-1:0] draw_dp_result;
    logic [`ANT_RESULT_WIDTH-1:0] update_dp_result;
    // Shared request path into the datapath port
    logic                         sel_req;
    instr_t                       sel_instr;
    logic                         dp_done;
    logic [`ANT_RESULT_WIDTH-1:0] dp_result;

    dp_select u_select (
        .clock            (clock),
        .resetn           (resetn),
        .start            (start),
        .cmd              (cmd),
        .finished         (finished),
        .draw_start       (draw_start),
        .update_start     (update_start),
        .draw_done        (draw_done),
        .update_done      (update_done),
        .draw_req         (draw_req),
        .update_req       (update_req),
        .draw_instr       (draw_instr),
        .update_instr     (update_instr),
        .req              (sel_req),
        .instr            (sel_instr),
        .done             (dp_done),
        .result           (dp_result),
        .draw_dp_done     (draw_dp_done),
        .update_dp_done   (update_dp_done),
        .draw_dp_result   (draw_dp_result),
        .update_dp_result (update_dp_result)
    );

    ant_draw u_draw (
        .clock    (clock),
        .resetn   (resetn),
        .start    (draw_start),
        .done_cmd (draw_done),
        .id       (id),
        .req      (draw_req),
        .instr    (draw_instr),
        .done     (draw_dp_done),
        .result   (draw_dp_result)
    );

    ant_update u_update (
        .clock    (clock),
        .resetn   (resetn),
        .start    (update_start),
        .done_cmd (update_done),
        .id       (id),
        .move     (move),
        .req      (update_req),
        .instr    (update_instr),
        .done     (update_dp_done),
        .result   (update_dp_result)
    );

    dp_request u_request (
        .clock          (clock),
        .resetn         (resetn),
        .req            (sel_req),
        .instr          (sel_instr),
        .done           (dp_done),
        .result         (dp_result),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

endmodule

`default_nettype wire

// ==== dv/ant_unit_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module ant_unit_checker (
    input logic clock,
    input logic resetn,
    input logic start_dp,
    input logic finished_dp,
    input logic finished
);

    // Every strobe covers a second cycle
    strobe_min_two: assert property (@(posedge clock) disable iff (!resetn)
        $rose(start_dp) |=> start_dp)
        else $error("start_dp was high for only one cycle");

    // and never a third
    strobe_max_two: assert property (@(posedge clock) disable iff (!resetn)
        start_dp && $past(start_dp) |=> !start_dp)
        else $error("start_dp stayed high for more than two cycles");

    // Completion only once the strobe is over
    no_finish_in_strobe: assert property (@(posedge clock) disable iff (!resetn)
        start_dp |-> !finished_dp)
        else $error("finished_dp arrived while start_dp was high");

    busy_in_strobe: assert property (@(posedge clock) disable iff (!resetn)
        start_dp |-> !finished)
        else $error("finished was high during a datapath strobe");

endmodule

bind ant_unit ant_unit_checker u_checker (
    .clock       (clock),
    .resetn      (resetn),
    .start_dp    (start_dp),
    .finished_dp (finished_dp),
    .finished    (finished)
);

`default_nettype wire

// ==== dv/ant_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ant_cfg.svh"

module ant_unit_tb;

    import ant_pkg::*;

    localparam int NUM_ROWS = 14;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 * 8;
    localparam int MEM_DEPTH = 1 << `ANT_ID_WIDTH;
    localparam int PIXELS = `ANT_BLOCK_WIDTH * `ANT_BLOCK_HEIGHT;

    typedef struct {
        string                    name;
        ant_cmd_e                 cmd;
        logic [`ANT_ID_WIDTH-1:0] id;
        move_t                    move;
        logic [`ANT_X_WIDTH-1:0]  preset_x;
        logic [`ANT_Y_WIDTH-1:0]  preset_y;
        logic [`ANT_X_WIDTH-1:0]  exp_x;
        logic [`ANT_Y_WIDTH-1:0]  exp_y;
        bit                       busy_start;
    } row_t;

    logic                         clock;
    logic                         resetn;
    logic                         start;
    ant_cmd_e                     cmd;
    logic [`ANT_ID_WIDTH-1:0]     id;
    move_t                        move;
    logic                         finished;
    logic                         start_dp;
    instr_t                       instruction_dp;
    logic                         finished_dp;
    logic [`ANT_RESULT_WIDTH-1:0] result_dp;

    // Datapath model state
    logic [`ANT_X_WIDTH-1:0]      x_mem [MEM_DEPTH];
    logic [`ANT_Y_WIDTH-1:0]      y_mem [MEM_DEPTH];
    instr_t                       draw_log [$];
    int                           strobe_count;

    row_t                         rows [NUM_ROWS];
    int                           row_fill;
    int                           error_count;
    int                           tests_run;
    int                           tests_failed;
    int                           cycle_count = 0;

    ant_unit u_dut (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .cmd            (cmd),
        .id             (id),
        .move           (move),
        .finished       (finished),
        .start_dp       (start_dp),
        .instruction_dp (instruction_dp),
        .finished_dp    (finished_dp),
        .result_dp      (result_dp)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT did not complete the tests within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic check_value(input string test, input string what, input int expected,
                               input int actual);
        assert (expected == actual) else begin
            $display("ERROR %s: %s expected %0h actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_row(input string name, input ant_cmd_e c,
                           input logic [`ANT_ID_WIDTH-1:0] ant_id, input move_t mv,
                           input logic [`ANT_X_WIDTH-1:0] px, input logic [`ANT_Y_WIDTH-1:0] py,
                           input logic [`ANT_X_WIDTH-1:0] ex, input logic [`ANT_Y_WIDTH-1:0] ey,
                           input bit busy);
        row_t r;
        r.name       = name;
        r.cmd        = c;
        r.id         = ant_id;
        r.move       = mv;
        r.preset_x   = px;
        r.preset_y   = py;
        r.exp_x      = ex;
        r.exp_y      = ey;
        r.busy_start = busy;
        rows[row_fill] = r;
        row_fill++;
    endtask

    // Answers each two cycle strobe after a random latency
    task automatic run_datapath();
        instr_t cur;
        int     delay;
        forever begin
            next_cycle();
            if (start_dp) begin
                cur = instruction_dp;
                strobe_count++;
                delay = 1 + int'($urandom % 4);
                repeat (1 + delay) next_cycle();
                case (cur.mem.opcode)
                    op_mem_read: begin
                        result_dp = (cur.mem.addr.field == field_x) ? x_mem[cur.mem.addr.id]
                                  : `ANT_RESULT_WIDTH'(y_mem[cur.mem.addr.id]);
                    end
                    op_mem_write: begin
                        if (cur.mem.addr.field == field_x) begin
                            x_mem[cur.mem.addr.id] = cur.mem.wdata[`ANT_X_WIDTH-1:0];
                        end else begin
                            y_mem[cur.mem.addr.id] = cur.mem.wdata[`ANT_Y_WIDTH-1:0];
                        end
                    end
                    op_draw: draw_log.push_back(cur);
                    default: result_dp = '0;
                endcase
                finished_dp = 1'b1;
                next_cycle();
                finished_dp = 1'b0;
                result_dp   = '0;
            end
        end
    endtask

    task automatic run_row(input row_t r);
        logic [`ANT_X_WIDTH-1:0]  x_before [MEM_DEPTH];
        logic [`ANT_Y_WIDTH-1:0]  y_before [MEM_DEPTH];
        logic [`ANT_ID_WIDTH-1:0] idx;
        instr_t                   exp_instr;
        int                       errors_before;
        int                       k;
        int                       dx;
        int                       dy;
        errors_before = error_count;
        x_mem[r.id] = r.preset_x;
        y_mem[r.id] = r.preset_y;
        for (k = 0; k < MEM_DEPTH; k++) begin
            idx = `ANT_ID_WIDTH'(k);
            x_before[idx] = x_mem[idx];
            y_before[idx] = y_mem[idx];
        end
        draw_log.delete();
        strobe_count = 0;

        cmd   = r.cmd;
        id    = r.id;
        move  = r.move;
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        assert (!finished) else begin
            $display("%s: the start pulse was not accepted", r.name);
            error_count++;
        end
        if (r.busy_start) begin
            repeat (3) next_cycle();
            assert (!finished) else begin
                $display("%s: the command ended before the second start", r.name);
                error_count++;
            end
            // Second command with other operands, which the DUT must drop
            cmd   = (r.cmd == cmd_draw) ? cmd_update : cmd_draw;
            id    = r.id ^ `ANT_ID_WIDTH'(5);
            move  = ~r.move;
            start = 1'b1;
            next_cycle();
            start = 1'b0;
        end
        while (!finished) next_cycle();
        repeat (4) next_cycle();

        check_value(r.name, "transaction count",
                    (r.cmd == cmd_draw) ? 2 + PIXELS : 4, strobe_count);
        check_value(r.name, "draw count", (r.cmd == cmd_draw) ? PIXELS : 0, draw_log.size());
        if (r.cmd == cmd_draw) begin
            for (dy = 0; dy < `ANT_BLOCK_HEIGHT; dy++) begin
                for (dx = 0; dx < `ANT_BLOCK_WIDTH; dx++) begin
                    k = dy * `ANT_BLOCK_WIDTH + dx;
                    exp_instr             = '0;
                    exp_instr.draw.opcode = op_draw;
                    exp_instr.draw.plot   = 1'b1;
                    exp_instr.draw.colour = `ANT_COLOUR;
                    exp_instr.draw.x      = `ANT_X_WIDTH'(int'(r.preset_x) - 1 + dx);
                    exp_instr.draw.y      = `ANT_Y_WIDTH'(int'(r.preset_y) - 1 + dy);
                    if (k < draw_log.size()) begin
                        check_value(r.name, $sformatf("pixel %0d", k), int'(exp_instr),
                                    int'(draw_log[k]));
                    end
                end
            end
        end
        check_value(r.name, "stored x", int'(r.exp_x), int'(x_mem[r.id]));
        check_value(r.name, "stored y", int'(r.exp_y), int'(y_mem[r.id]));
        for (k = 0; k < MEM_DEPTH; k++) begin
            idx = `ANT_ID_WIDTH'(k);
            if (idx != r.id) begin
                check_value(r.name, $sformatf("x of ant %0d", k), int'(x_before[idx]),
                            int'(x_mem[idx]));
                check_value(r.name, $sformatf("y of ant %0d", k), int'(y_before[idx]),
                            int'(y_mem[idx]));
            end
        end

        tests_run++;
        if (error_count == errors_before) begin
            $display("PASS %s", r.name);
        end else begin
            $display("FAIL %s", r.name);
            tests_failed++;
        end
    endtask

    initial begin
        int                       k;
        int                       errors_before;
        logic [`ANT_ID_WIDTH-1:0] idx;
        void'($urandom(32'habd3));
        resetn       = 1'b0;
        start        = 1'b0;
        cmd          = cmd_draw;
        id           = '0;
        move         = '0;
        finished_dp  = 1'b0;
        result_dp    = '0;
        strobe_count = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        row_fill     = 0;
        for (k = 0; k < MEM_DEPTH; k++) begin
            idx = `ANT_ID_WIDTH'(k);
            x_mem[idx] = `ANT_X_WIDTH'(k * 29 + 7);
            y_mem[idx] = `ANT_Y_WIDTH'(k * 13 + 3);
        end

        add_row("draw_mid", cmd_draw, 4'd3, 4'b0000, 8'd20, 7'd30, 8'd20, 7'd30, 1'b0);
        add_row("draw_wrap", cmd_draw, 4'd0, 4'b0000, 8'd0, 7'd0, 8'd0, 7'd0, 1'b0);
        add_row("move_left", cmd_update, 4'd5, 4'b1000, 8'd10, 7'd10, 8'd9, 7'd10, 1'b0);
        add_row("move_right", cmd_update, 4'd6, 4'b0100, 8'd10, 7'd10, 8'd11, 7'd10, 1'b0);
        add_row("move_up", cmd_update, 4'd7, 4'b0010, 8'd40, 7'd50, 8'd40, 7'd49, 1'b0);
        add_row("move_down", cmd_update, 4'd8, 4'b0001, 8'd40, 7'd50, 8'd40, 7'd51, 1'b0);
        add_row("cancel_x", cmd_update, 4'd1, 4'b1100, 8'd60, 7'd20, 8'd60, 7'd20, 1'b0);
        add_row("cancel_y", cmd_update, 4'd2, 4'b0011, 8'd60, 7'd20, 8'd60, 7'd20, 1'b0);
        add_row("wrap_x_low", cmd_update, 4'd10, 4'b1000, 8'd0, 7'd5, 8'd255, 7'd5, 1'b0);
        add_row("wrap_x_high", cmd_update, 4'd11, 4'b0100, 8'd255, 7'd5, 8'd0, 7'd5, 1'b0);
        add_row("wrap_y_low", cmd_update, 4'd12, 4'b0010, 8'd9, 7'd0, 8'd9, 7'd127, 1'b0);
        add_row("wrap_y_high", cmd_update, 4'd13, 4'b0001, 8'd9, 7'd127, 8'd9, 7'd0, 1'b0);
        add_row("update_busy", cmd_update, 4'd14, 4'b0101, 8'd77, 7'd33, 8'd78, 7'd34, 1'b1);
        add_row("draw_busy", cmd_draw, 4'd9, 4'b0000, 8'd100, 7'd60, 8'd100, 7'd60, 1'b1);

        fork
            run_datapath();
        join_none

        repeat (10) @(posedge clock);
        #2;
        resetn = 1'b1;

        // Idle DUT with no start
        errors_before = error_count;
        repeat (5) next_cycle();
        check_value("reset_idle", "finished", 1, int'(finished));
        check_value("reset_idle", "start_dp", 0, int'(start_dp));
        check_value("reset_idle", "instruction_dp", 0, int'(instruction_dp));
        check_value("reset_idle", "transaction count", 0, strobe_count);
        tests_run++;
        if (error_count == errors_before) begin
            $display("PASS reset_idle");
        end else begin
            $display("FAIL reset_idle");
            tests_failed++;
        end

        for (k = 0; k < NUM_ROWS; k++) begin
            run_row(rows[k]);
        end

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/ant_pkg.sv
hw/dp_request.sv
hw/ant_draw.sv
hw/ant_update.sv
hw/dp_select.sv
hw/ant_unit.sv
dv/ant_unit_checker.sv
dv/ant_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ant unit testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary -j 0 --assert --timescale 1ns/100ps --top-module ant_unit_tb \
    -f sources.f -o ant_unit_sim \
    && ./obj_dir/ant_unit_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with errors" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
